// File: build.f
src/switch_pkg.sv
src/ip_port_mapper.sv
src/rr_arbiter.sv
src/port_scheduler.sv
src/drop_handler.sv
src/stream_crossbar.sv
src/port_controller.sv
src/packet_switch.sv
testbench/tb_packet_switch.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_packet_switch -f build.f

status=0
output=$(./obj_dir/Vtb_packet_switch 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
	exit 0
fi
echo "simulation failed, exit status $status"
exit 1

// File: testbench/tb_packet_switch.sv
`timescale 1ns/10ps

module tb_packet_switch;

	localparam int max_pkts = 16;
	localparam int max_bytes = 9;
	localparam int exp_depth = 256;
	localparam int cycle_budget = 2000;

	logic clk;
	logic resetn;
	switch_pkg::byte_beat_t src_byte [switch_pkg::num_src];
	switch_pkg::meta_beat_t src_meta [switch_pkg::num_src];
	logic [switch_pkg::num_src-1:0] src_byte_ready;
	logic [switch_pkg::num_src-1:0] src_meta_ready;
	switch_pkg::word_beat_t port_word [switch_pkg::num_port];
	logic [switch_pkg::num_port-1:0] port_word_ready;
	switch_pkg::drop_count_t dropped_count;

	packet_switch u_packet_switch (
		.clk(clk),
		.resetn(resetn),
		.src_byte(src_byte),
		.src_meta(src_meta),
		.src_byte_ready(src_byte_ready),
		.src_meta_ready(src_meta_ready),
		.port_word(port_word),
		.port_word_ready(port_word_ready),
		.dropped_count(dropped_count)
	);

	logic [31:0] lfsr_state;

	// Packets queued per source
	logic [31:0] pkt_ip [switch_pkg::num_src][max_pkts];
	int pkt_len [switch_pkg::num_src][max_pkts];
	logic [7:0] pkt_data [switch_pkg::num_src][max_pkts][max_bytes];
	int pkt_cnt [switch_pkg::num_src];
	int pkt_idx [switch_pkg::num_src];
	int byte_idx [switch_pkg::num_src];
	logic [switch_pkg::num_src-1:0] active;
	logic [switch_pkg::num_src-1:0] meta_done;

	// Expected {data, last} per port in header order
	logic [32:0] exp_word [switch_pkg::num_port][exp_depth];
	int exp_head [switch_pkg::num_port];
	int exp_tail [switch_pkg::num_port];
	int order_log [max_pkts * switch_pkg::num_src];
	int order_cnt;

	// Handshakes seen before the last rising edge
	logic [switch_pkg::num_src-1:0] byte_fire;
	logic [switch_pkg::num_src-1:0] meta_fire;
	logic [switch_pkg::num_port-1:0] word_fire;
	logic [32:0] word_seen [switch_pkg::num_port];

	logic use_gaps;
	logic ready_random;
	int queued_total;
	int model_drops;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int cycle_count;
	string test_name;

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Random numbers and the routing model
	////////////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// 192.168.1.1 to .3 reach ports a to c and anything else is dropped
	function automatic int route_port(input logic [31:0] ip);
		if (ip[31:8] == 24'hc0a801 && ip[7:0] >= 8'd1 && ip[7:0] <= 8'd3) begin
			return int'(ip[7:0]) - 1;
		end
		return -1;
	endfunction

	function automatic logic [31:0] port_addr(input int p);
		return {24'hc0a801, 8'(p + 1)};
	endfunction

	function automatic int random_len();
		logic [31:0] r;
		r = rand_bits(4);
		return 1 + int'(r) % max_bytes;
	endfunction

	function automatic logic [31:0] random_addr(input logic allow_invalid);
		logic [31:0] kind;
		logic [7:0] host;
		kind = rand_bits(3);
		host = 8'(rand_bits(8));
		if (allow_invalid && kind[2:0] == 3'd0) begin
			kind = rand_bits(2);
			case (kind[1:0])
				2'd0: return {24'h0a0000, host};
				2'd1: return {24'hc0a801, 8'd0};
				2'd2: return {24'hc0a801, 8'd4 + {2'b00, host[5:0]}};
				default: return {24'hc0a802, host};
			endcase
		end
		kind = rand_bits(2);
		return port_addr(int'(kind[1:0]) % switch_pkg::num_port);
	endfunction

	task automatic add_packet(input int s, input logic [31:0] ip, input int len);
		int n;
		n = pkt_cnt[s];
		pkt_ip[s][n] = ip;
		pkt_len[s][n] = len;
		for (int i = 0; i < len; i++) begin
			pkt_data[s][n][i] = 8'(rand_bits(8));
		end
		pkt_cnt[s] = n + 1;
		queued_total++;
		if (route_port(ip) < 0) begin
			model_drops++;
		end
	endtask

	// Header word followed by bytes packed from bit 0 upward with zero padding
	task automatic expect_packet(input int s, input int n);
		int p;
		logic [31:0] w;
		p = route_port(pkt_ip[s][n]);
		exp_word[p][exp_tail[p] % exp_depth] = {pkt_ip[s][n], 1'b0};
		exp_tail[p]++;
		w = '0;
		for (int i = 0; i < pkt_len[s][n]; i++) begin
			w[(i % 4) * 8 +: 8] = pkt_data[s][n][i];
			if (i % 4 == 3 || i == pkt_len[s][n] - 1) begin
				exp_word[p][exp_tail[p] % exp_depth] = {w, i == pkt_len[s][n] - 1};
				exp_tail[p]++;
				w = '0;
			end
		end
		if (p == 0) begin
			order_log[order_cnt] = s;
			order_cnt++;
		end
	endtask

	task automatic check_word(input int p, input logic [32:0] got);
		logic ok;
		logic [32:0] want;
		checks++;
		ok = exp_head[p] != exp_tail[p];
		assert (ok) else begin
			errors++;
			$display("test %s: port %0d gave word %h while nothing was expected",
				test_name, p, got[32:1]);
		end
		if (ok) begin
			want = exp_word[p][exp_head[p] % exp_depth];
			exp_head[p]++;
			assert (got == want) else begin
				errors++;
				$display("mismatch test %s port %0d: expected %h last %0b, actual %h last %0b",
					test_name, p, want[32:1], want[0], got[32:1], got[0]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Source drivers that advance one clock cycle per call
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_source(input int s);
		logic hold;
		hold = src_byte[s].valid && !byte_fire[s];
		if (byte_fire[s]) begin
			byte_idx[s]++;
		end
		if (active[s] && meta_done[s] && byte_idx[s] == pkt_len[s][pkt_idx[s]]) begin
			active[s] = 1'b0;
			pkt_idx[s]++;
		end
		if (!active[s] && pkt_idx[s] < pkt_cnt[s]) begin
			active[s] = 1'b1;
			meta_done[s] = 1'b0;
			byte_idx[s] = 0;
		end
		src_meta[s] = '0;
		src_byte[s] = '0;
		if (active[s]) begin
			// Address stays up until the packet is fully handed over
			src_meta[s].valid = 1'b1;
			src_meta[s].ip = pkt_ip[s][pkt_idx[s]];
			if (byte_idx[s] < pkt_len[s][pkt_idx[s]]) begin
				src_byte[s].valid = hold || !use_gaps || rand_bits(2) != 0;
				src_byte[s].data = pkt_data[s][pkt_idx[s]][byte_idx[s]];
				src_byte[s].last = byte_idx[s] == pkt_len[s][pkt_idx[s]] - 1;
			end
		end
	endtask

	task automatic run_cycle();
		int dest;
		@(negedge clk);
		for (int s = 0; s < switch_pkg::num_src; s++) begin
			byte_fire[s] = src_byte[s].valid && src_byte_ready[s];
			meta_fire[s] = src_meta[s].valid && src_meta_ready[s];
		end
		for (int p = 0; p < switch_pkg::num_port; p++) begin
			word_fire[p] = port_word[p].valid && port_word_ready[p];
			word_seen[p] = {port_word[p].data, port_word[p].last};
		end
		@(posedge clk);
		#1;
		// A header is accepted in the same cycle as its metadata
		for (int s = 0; s < switch_pkg::num_src; s++) begin
			if (meta_fire[s] && active[s] && !meta_done[s]) begin
				meta_done[s] = 1'b1;
				dest = route_port(pkt_ip[s][pkt_idx[s]]);
				checks++;
				if (dest >= 0) begin
					assert (word_fire[dest]) else begin
						errors++;
						$display("test %s: source %0d metadata taken with no header on port %0d",
							test_name, s, dest);
					end
					expect_packet(s, pkt_idx[s]);
				end else begin
					// Dropped packets give back their metadata only after the last byte
					assert (byte_idx[s] == pkt_len[s][pkt_idx[s]]) else begin
						errors++;
						$display("test %s: source %0d drop released metadata before the last byte",
							test_name, s);
					end
				end
			end
		end
		for (int p = 0; p < switch_pkg::num_port; p++) begin
			if (word_fire[p]) begin
				check_word(p, word_seen[p]);
			end
			port_word_ready[p] = ready_random ? rand_bits(1) != 0 : 1'b1;
		end
		for (int s = 0; s < switch_pkg::num_src; s++) begin
			drive_source(s);
		end
	endtask

	function automatic logic all_done();
		for (int s = 0; s < switch_pkg::num_src; s++) begin
			if (active[s] || pkt_idx[s] < pkt_cnt[s]) begin
				return 1'b0;
			end
		end
		for (int p = 0; p < switch_pkg::num_port; p++) begin
			if (exp_head[p] != exp_tail[p]) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic clear_test();
		for (int s = 0; s < switch_pkg::num_src; s++) begin
			pkt_cnt[s] = 0;
			pkt_idx[s] = 0;
			byte_idx[s] = 0;
			active[s] = 1'b0;
			meta_done[s] = 1'b0;
		end
		for (int p = 0; p < switch_pkg::num_port; p++) begin
			exp_head[p] = 0;
			exp_tail[p] = 0;
		end
		order_cnt = 0;
	endtask

	task automatic run_test(input string name, input logic gaps, input logic backpressure,
			input logic check_order);
		int err_before;
		test_name = name;
		use_gaps = gaps;
		ready_random = backpressure;
		err_before = errors;
		while (!all_done()) begin
			run_cycle();
		end
		// Quiet period so that any stray word is caught
		repeat (12) run_cycle();
		checks++;
		assert (dropped_count == switch_pkg::drop_count_t'(model_drops)) else begin
			errors++;
			$display("mismatch test %s dropped_count: expected %0d, actual %0d",
				name, model_drops, dropped_count);
		end
		if (check_order) begin
			checks++;
			assert (order_cnt == 2 * switch_pkg::num_src) else begin
				errors++;
				$display("test %s: port a took %0d headers instead of %0d",
					name, order_cnt, 2 * switch_pkg::num_src);
			end
			for (int i = 0; i < order_cnt; i++) begin
				checks++;
				assert (order_log[i] == i % switch_pkg::num_src) else begin
					errors++;
					$display("mismatch test %s header %0d source: expected %0d, actual %0d",
						name, i, i % switch_pkg::num_src, order_log[i]);
				end
			end
		end
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		lfsr_state = 32'h43c4f5b4;
		resetn = 1'b0;
		port_word_ready = '0;
		for (int s = 0; s < switch_pkg::num_src; s++) begin
			src_byte[s] = '0;
			src_meta[s] = '0;
		end
		byte_fire = '0;
		clear_test();
		repeat (4) @(posedge clk);
		#1;
		resetn = 1'b1;
		port_word_ready = '1;

		// Lengths cover a padded word, a full word and three words
		add_packet(0, port_addr(0), 3);
		add_packet(1, port_addr(1), 4);
		add_packet(2, port_addr(2), 9);
		run_test("single_per_port", 1'b0, 1'b0, 1'b0);

		clear_test();
		add_packet(0, 32'h0a000001, random_len());
		add_packet(0, port_addr(1), random_len());
		add_packet(1, {24'hc0a801, 8'd0}, random_len());
		add_packet(1, {24'hc0a801, 8'd4}, random_len());
		add_packet(1, port_addr(2), random_len());
		add_packet(2, {24'hc0a801, 8'd200}, random_len());
		add_packet(2, 32'hc0a80201, random_len());
		add_packet(2, port_addr(0), random_len());
		run_test("invalid_drop", 1'b1, 1'b0, 1'b0);

		clear_test();
		for (int k = 0; k < 2; k++) begin
			for (int s = 0; s < switch_pkg::num_src; s++) begin
				add_packet(s, port_addr(0), random_len());
			end
		end
		run_test("round_robin", 1'b0, 1'b0, 1'b1);

		clear_test();
		for (int s = 0; s < switch_pkg::num_src; s++) begin
			for (int k = 0; k < 5; k++) begin
				add_packet(s, random_addr(1'b0), random_len());
			end
		end
		run_test("backpressure", 1'b1, 1'b1, 1'b0);

		clear_test();
		for (int s = 0; s < switch_pkg::num_src; s++) begin
			for (int k = 0; k < 10; k++) begin
				add_packet(s, random_addr(1'b1), random_len());
			end
		end
		run_test("random_mix", 1'b1, 1'b1, 1'b0);

		$display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, checks, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Budget grows as packets are queued
	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_budget * (queued_total + 1)) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("watchdog: no finish after %0d cycles with %0d packets queued",
			cycle_count, queued_total);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: src/packet_switch.sv
`timescale 1ns/10ps

module packet_switch (
	input logic clk,
	input logic resetn,
	input switch_pkg::byte_beat_t src_byte [switch_pkg::num_src],
	input switch_pkg::meta_beat_t src_meta [switch_pkg::num_src],
	output logic [switch_pkg::num_src-1:0] src_byte_ready,
	output logic [switch_pkg::num_src-1:0] src_meta_ready,
	output switch_pkg::word_beat_t port_word [switch_pkg::num_port],
	input logic [switch_pkg::num_port-1:0] port_word_ready,
	output switch_pkg::drop_count_t dropped_count
);

	logic [switch_pkg::num_port-1:0] port_sel [switch_pkg::num_src];
	logic [switch_pkg::num_src-1:0] invalid;
	logic [switch_pkg::num_src-1:0] src_busy;
	logic [switch_pkg::num_src-1:0] request [switch_pkg::num_port];
	switch_pkg::src_sel_t grant [switch_pkg::num_port];
	switch_pkg::src_sel_t sched_src [switch_pkg::num_port];
	logic [switch_pkg::num_port-1:0] start;
	logic [switch_pkg::num_port-1:0] ctrl_idle;
	logic [switch_pkg::num_port-1:0] ctrl_byte_ready;
	logic [switch_pkg::num_port-1:0] ctrl_meta_ready;
	switch_pkg::byte_beat_t ctrl_byte [switch_pkg::num_port];
	switch_pkg::meta_beat_t ctrl_meta [switch_pkg::num_port];
	logic [switch_pkg::num_src-1:0] drop_byte_ready;
	logic [switch_pkg::num_src-1:0] drop_meta_ready;
	switch_pkg::drop_count_t drop_count [switch_pkg::num_src];

	// A source still held by a port finishing its tail does not request again
	always_comb begin
		for (int s = 0; s < switch_pkg::num_src; s++) begin
			src_busy[s] = 1'b0;
			for (int p = 0; p < switch_pkg::num_port; p++) begin
				if (sched_src[p] == switch_pkg::src_sel_t'(s + 1)) begin
					src_busy[s] = 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int p = 0; p < switch_pkg::num_port; p++) begin
			for (int s = 0; s < switch_pkg::num_src; s++) begin
				request[p][s] = src_byte[s].valid && port_sel[s][p] && !src_busy[s];
			end
		end
	end

	always_comb begin
		dropped_count = '0;
		for (int s = 0; s < switch_pkg::num_src; s++) begin
			dropped_count = dropped_count + drop_count[s];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Per source
	////////////////////////////////////////////////////////////////////////////

	for (genvar s = 0; s < switch_pkg::num_src; s++) begin : g_src
		ip_port_mapper u_mapper (
			.ip(src_meta[s].ip),
			.port_onehot(port_sel[s]),
			.invalid(invalid[s])
		);

		drop_handler u_drop (
			.clk(clk),
			.resetn(resetn),
			.invalid(invalid[s]),
			.byte_beat(src_byte[s]),
			.byte_ready(drop_byte_ready[s]),
			.meta_ready(drop_meta_ready[s]),
			.count(drop_count[s])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Per port
	////////////////////////////////////////////////////////////////////////////

	for (genvar p = 0; p < switch_pkg::num_port; p++) begin : g_port
		rr_arbiter u_arbiter (
			.clk(clk),
			.resetn(resetn),
			.request(request[p]),
			.advance(start[p]),
			.grant(grant[p])
		);

		port_scheduler u_scheduler (
			.clk(clk),
			.resetn(resetn),
			.request_any(|request[p]),
			.ctrl_idle(ctrl_idle[p]),
			.grant(grant[p]),
			.start(start[p]),
			.sched_src(sched_src[p])
		);

		port_controller u_controller (
			.clk(clk),
			.resetn(resetn),
			.start(start[p]),
			.byte_beat(ctrl_byte[p]),
			.meta(ctrl_meta[p]),
			.byte_ready(ctrl_byte_ready[p]),
			.meta_ready(ctrl_meta_ready[p]),
			.word(port_word[p]),
			.word_ready(port_word_ready[p]),
			.ctrl_idle(ctrl_idle[p])
		);
	end

	stream_crossbar u_crossbar (
		.sched_src(sched_src),
		.src_byte(src_byte),
		.src_meta(src_meta),
		.invalid(invalid),
		.drop_byte_ready(drop_byte_ready),
		.drop_meta_ready(drop_meta_ready),
		.ctrl_byte_ready(ctrl_byte_ready),
		.ctrl_meta_ready(ctrl_meta_ready),
		.ctrl_byte(ctrl_byte),
		.ctrl_meta(ctrl_meta),
		.src_byte_ready(src_byte_ready),
		.src_meta_ready(src_meta_ready)
	);

endmodule

// File: src/port_controller.sv
`timescale 1ns/10ps

module port_controller (
	input logic clk,
	input logic resetn,
	input logic start,
	input switch_pkg::byte_beat_t byte_beat,
	input switch_pkg::meta_beat_t meta,
	output logic byte_ready,
	output logic meta_ready,
	output switch_pkg::word_beat_t word,
	input logic word_ready,
	output logic ctrl_idle
);

	logic busy;
	// Header word has been placed in the output register
	logic hdr_loaded;
	// Output register currently holds the header
	logic out_hdr;
	// Final byte of the packet has been taken
	logic done;
	// Next byte lane in the word being packed
	logic [1:0] cnt;
	switch_pkg::word_beat_t word_q;
	logic byte_take;
	logic word_take;

	assign ctrl_idle = !busy;
	assign word = word_q;
	assign word_take = word_q.valid && word_ready;

	// Bytes flow only while no word is waiting on the output
	assign byte_ready = busy && hdr_loaded && !done && !word_q.valid;
	assign byte_take = byte_ready && byte_beat.valid;

	// Metadata is released together with the header handshake
	assign meta_ready = word_take && out_hdr;

	////////////////////////////////////////////////////////////////////////////
	// Header and packing datapath
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			hdr_loaded <= 1'b0;
			out_hdr <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
			word_q.valid <= 1'b0;
		end else begin
			if (start) begin
				busy <= 1'b1;
				hdr_loaded <= 1'b0;
				done <= 1'b0;
				cnt <= '0;
			end

			if (busy && !hdr_loaded && meta.valid && !word_q.valid) begin
				word_q.valid <= 1'b1;
				word_q.data <= meta.ip;
				word_q.last <= 1'b0;
				hdr_loaded <= 1'b1;
				out_hdr <= 1'b1;
			end else if (byte_take) begin
				// First byte of a word clears the upper lanes for padding
				if (cnt == 2'd0) begin
					word_q.data <= switch_pkg::word_t'(byte_beat.data);
				end else begin
					word_q.data[{cnt, 3'b000} +: 8] <= byte_beat.data;
				end
				cnt <= cnt + 2'd1;
				if (cnt == 2'd3 || byte_beat.last) begin
					word_q.valid <= 1'b1;
					word_q.last <= byte_beat.last;
					cnt <= '0;
				end
				if (byte_beat.last) begin
					done <= 1'b1;
				end
			end

			if (word_take) begin
				word_q.valid <= 1'b0;
				out_hdr <= 1'b0;
				if (word_q.last) begin
					busy <= 1'b0;
				end
			end
		end
	end

	a_word_hold: assert property (
		@(posedge clk) disable iff (!resetn)
		(word_q.valid && !word_ready) |=> (word_q.valid && $stable(word_q.data))
	) else $error("port_controller: output word changed under back-pressure");

endmodule

// File: src/stream_crossbar.sv
`timescale 1ns/10ps

module stream_crossbar (
	input switch_pkg::src_sel_t sched_src [switch_pkg::num_port],
	input switch_pkg::byte_beat_t src_byte [switch_pkg::num_src],
	input switch_pkg::meta_beat_t src_meta [switch_pkg::num_src],
	input logic [switch_pkg::num_src-1:0] invalid,
	input logic [switch_pkg::num_src-1:0] drop_byte_ready,
	input logic [switch_pkg::num_src-1:0] drop_meta_ready,
	input logic [switch_pkg::num_port-1:0] ctrl_byte_ready,
	input logic [switch_pkg::num_port-1:0] ctrl_meta_ready,
	output switch_pkg::byte_beat_t ctrl_byte [switch_pkg::num_port],
	output switch_pkg::meta_beat_t ctrl_meta [switch_pkg::num_port],
	output logic [switch_pkg::num_src-1:0] src_byte_ready,
	output logic [switch_pkg::num_src-1:0] src_meta_ready
);

	////////////////////////////////////////////////////////////////////////////
	// Source to port
	////////////////////////////////////////////////////////////////////////////

	// Unscheduled ports see an all zero stream
	always_comb begin
		for (int p = 0; p < switch_pkg::num_port; p++) begin
			ctrl_byte[p] = '0;
			ctrl_meta[p] = '0;
			for (int s = 0; s < switch_pkg::num_src; s++) begin
				if (sched_src[p] == switch_pkg::src_sel_t'(s + 1)) begin
					ctrl_byte[p] = src_byte[s];
					ctrl_meta[p] = src_meta[s];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Port to source
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int s = 0; s < switch_pkg::num_src; s++) begin
			src_byte_ready[s] = 1'b0;
			src_meta_ready[s] = 1'b0;
			if (invalid[s]) begin
				// Drop handler owns this source
				src_byte_ready[s] = drop_byte_ready[s];
				src_meta_ready[s] = drop_meta_ready[s];
			end else begin
				for (int p = 0; p < switch_pkg::num_port; p++) begin
					if (sched_src[p] == switch_pkg::src_sel_t'(s + 1)) begin
						src_byte_ready[s] = ctrl_byte_ready[p];
						src_meta_ready[s] = ctrl_meta_ready[p];
					end
				end
			end
		end
	end

	// A source may be routed to at most one port
	for (genvar s = 0; s < switch_pkg::num_src; s++) begin : g_once
		logic [switch_pkg::num_port-1:0] hit;

		always_comb begin
			for (int p = 0; p < switch_pkg::num_port; p++) begin
				hit[p] = (sched_src[p] == switch_pkg::src_sel_t'(s + 1));
			end
		end

		always_comb begin
			a_single_port: assert final ($onehot0(hit))
				else $error("stream_crossbar: source %0d scheduled on two ports", s);
		end
	end

endmodule

// File: src/drop_handler.sv
`timescale 1ns/10ps

module drop_handler (
	input logic clk,
	input logic resetn,
	input logic invalid,
	input switch_pkg::byte_beat_t byte_beat,
	output logic byte_ready,
	output logic meta_ready,
	output switch_pkg::drop_count_t count
);

	switch_pkg::drop_state_t state;

	// Bytes are sunk for the whole packet once draining starts
	assign byte_ready = (state == switch_pkg::consume_invalid);

	////////////////////////////////////////////////////////////////////////////
	// Drain FSM and drop counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= switch_pkg::wait_invalid;
			meta_ready <= 1'b0;
			count <= '0;
		end else begin
			meta_ready <= 1'b0;
			case (state)
				switch_pkg::wait_invalid: begin
					// Old metadata is still up while meta_ready pulses
					if (invalid && byte_beat.valid && !meta_ready) begin
						count <= count + 1'b1;
						state <= switch_pkg::consume_invalid;
					end
				end
				switch_pkg::consume_invalid: begin
					if (byte_beat.valid && byte_beat.last) begin
						// Release the metadata after the final byte
						meta_ready <= 1'b1;
						state <= switch_pkg::wait_invalid;
					end
				end
				default: begin
					state <= switch_pkg::wait_invalid;
				end
			endcase
		end
	end

endmodule

// File: src/port_scheduler.sv
`timescale 1ns/10ps

module port_scheduler (
	input logic clk,
	input logic resetn,
	input logic request_any,
	input logic ctrl_idle,
	input switch_pkg::src_sel_t grant,
	output logic start,
	output switch_pkg::src_sel_t sched_src
);

	switch_pkg::sched_state_t state;

	////////////////////////////////////////////////////////////////////////////
	// Transfer scheduling FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= switch_pkg::wait_schedule;
			start <= 1'b0;
			sched_src <= '0;
		end else begin
			// Start is a single cycle pulse
			start <= 1'b0;
			case (state)
				switch_pkg::wait_schedule: begin
					if (request_any && ctrl_idle) begin
						start <= 1'b1;
						sched_src <= grant;
						state <= switch_pkg::scheduled;
					end
				end
				switch_pkg::scheduled: begin
					// Controller is still idle during the start cycle itself
					if (ctrl_idle && !start) begin
						sched_src <= '0;
						state <= switch_pkg::wait_schedule;
					end
				end
				default: begin
					state <= switch_pkg::wait_schedule;
				end
			endcase
		end
	end

	a_start_single: assert property (
		@(posedge clk) disable iff (!resetn)
		start |=> !start
	) else $error("port_scheduler: start held for two cycles");

	a_src_while_scheduled: assert property (
		@(posedge clk) disable iff (!resetn)
		start |-> (sched_src != '0)
	) else $error("port_scheduler: start with no source selected");

endmodule

// File: src/rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter (
	input logic clk,
	input logic resetn,
	input logic [switch_pkg::num_src-1:0] request,
	input logic advance,
	output switch_pkg::src_sel_t grant
);

	// Index of the source searched first
	logic [1:0] ptr;
	// Grant from the decision cycle, which is the cycle before advance
	switch_pkg::src_sel_t grant_q;

	// Rotating priority, the lowest offset from ptr wins
	always_comb begin
		int idx;
		grant = '0;
		for (int k = switch_pkg::num_src - 1; k >= 0; k--) begin
			idx = (int'(ptr) + k) % switch_pkg::num_src;
			if (request[idx]) begin
				grant = switch_pkg::src_sel_t'(idx + 1);
			end
		end
	end

	always_ff @(posedge clk) begin
		grant_q <= grant;
	end

	// Source after the winner gets first pick next time
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ptr <= '0;
		end else if (advance && grant_q != '0) begin
			ptr <= 2'(int'(grant_q) % switch_pkg::num_src);
		end
	end

	a_grant_on_request: assert property (
		@(posedge clk) disable iff (!resetn)
		(|request) |-> (grant != '0)
	) else $error("rr_arbiter: request without grant");

endmodule

// File: src/ip_port_mapper.sv
`timescale 1ns/10ps

module ip_port_mapper (
	input switch_pkg::ip_addr_t ip,
	output logic [switch_pkg::num_port-1:0] port_onehot,
	output logic invalid
);

	logic in_subnet;

	// Network part must match before the host byte means anything
	assign in_subnet = (ip[31:8] == switch_pkg::subnet_prefix);

	always_comb begin
		port_onehot = '0;
		for (int p = 0; p < switch_pkg::num_port; p++) begin
			port_onehot[p] = in_subnet && (ip[7:0] == switch_pkg::port_host(p));
		end
	end

	// No port hit, so the packet gets drained
	assign invalid = ~|port_onehot;

endmodule

// File: src/switch_pkg.sv
package switch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int num_src = 3;
	localparam int num_port = 3;

	// 0 means no source, 1 to 3 select sources a to c
	typedef logic [1:0] src_sel_t;

	typedef logic [31:0] ip_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [31:0] drop_count_t;

	// 192.168.1.x is the only routed subnet
	localparam logic [23:0] subnet_prefix = 24'hc0a801;

	////////////////////////////////////////////////////////////////////////////
	// Stream beats
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic valid;
		byte_t data;
		logic last;
	} byte_beat_t;

	typedef struct packed {
		logic valid;
		ip_addr_t ip;
	} meta_beat_t;

	typedef struct packed {
		logic valid;
		word_t data;
		logic last;
	} word_beat_t;

	typedef enum logic {wait_schedule, scheduled} sched_state_t;
	typedef enum logic {wait_invalid, consume_invalid} drop_state_t;

	// Host byte that routes to port p: .1 goes to a, .2 to b, .3 to c
	function automatic byte_t port_host(input int p);
		return byte_t'(p + 1);
	endfunction

endpackage
